// File: hw/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	typedef logic [31:0] word_t;    // Data and instruction word
	typedef logic [4:0]  regAddr_t; // GPR number
	typedef logic [4:0]  shamt_t;
	typedef logic [5:0]  opcode_t;  // Primary opcode and funct share a width

	// Internal opcode after decode
	typedef enum logic [3:0]
	{
		opNop,
		opAddu,
		opSubu,
		opSll,
		opOri,
		opAddiu,
		opLui,
		opLw,
		opSw
	} instrOp_e;

	// Field positions inside the 32-bit word
	localparam int OPC_LSB   = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_LSB   = 0;
	localparam int IMM_W     = 16;

	// Primary opcodes
	localparam opcode_t OPC_SPECIAL = 6'h00; // R type, look at funct
	localparam opcode_t OPC_ADDIU   = 6'h09;
	localparam opcode_t OPC_ORI     = 6'h0d;
	localparam opcode_t OPC_LUI     = 6'h0f;
	localparam opcode_t OPC_LW      = 6'h23;
	localparam opcode_t OPC_SW      = 6'h2b;

	// Funct codes under SPECIAL
	localparam opcode_t FN_SLL  = 6'h00;
	localparam opcode_t FN_ADDU = 6'h21;
	localparam opcode_t FN_SUBU = 6'h23;

endpackage

`default_nettype wire

// File: hw/pipePkg.sv
`default_nettype none

package pipePkg;

	import mipsIsaPkg::*;

	// Stage count after decode
	typedef logic [2:0] timing_t;
	localparam timing_t NEVER_USED = 3'd7; // Operand not read

	// Input credit buffer
	localparam int IN_CREDITS = 2;
	localparam int IN_PTR_W   = $clog2(IN_CREDITS);
	localparam int IN_CNT_W   = $clog2(IN_CREDITS + 1);

	// Data memory, word addressed from result bits [7:2]
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);
	localparam int DMEM_LSB   = 2;

	typedef enum logic [1:0]
	{
		fwdReg,    // Register file value
		fwdExec,   // Producer now in execute
		fwdResult  // Producer now writing back
	} fwdSel_e;

	typedef struct packed
	{
		instrOp_e op;
		regAddr_t rAddr0; // rs side
		regAddr_t rAddr1; // rt side
		regAddr_t wAddr;
		timing_t  tuse0;
		timing_t  tuse1;
		timing_t  tnew;
		word_t    imm;    // Already extended
		shamt_t   shamt;
	} decoded_t;

	typedef struct packed
	{
		instrOp_e op;
		regAddr_t wAddr;
		timing_t  tnew;
		word_t    result;    // ALU value or memory address
		word_t    storeData;
		regAddr_t storeAddr; // Source register of store data
	} execOut_t;

	typedef struct packed
	{
		logic     regWrite;
		regAddr_t wAddr;
		word_t    wData;
		logic     memWrite;
		word_t    memAddr;
		word_t    memData;
	} retire_t;

endpackage

`default_nettype wire

// File: hw/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import mipsIsaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     instrValid,
	input  word_t    instr,
	output logic     creditReturn,
	input  logic     stall,
	input  word_t    rData0,
	input  word_t    rData1,
	output decoded_t head,
	output logic     headValid,
	output decoded_t issue,
	output logic     issueValid,
	output word_t    issueData0,
	output word_t    issueData1
);

	word_t               buffer [IN_CREDITS]; // Entries only, no reset
	logic [IN_PTR_W-1:0] wrPtr;
	logic [IN_PTR_W-1:0] rdPtr;
	logic [IN_CNT_W-1:0] count;
	logic                pop;
	word_t               headWord;
	opcode_t             opc;
	opcode_t             funct;
	regAddr_t            rs;
	regAddr_t            rt;
	regAddr_t            rd;
	logic [IMM_W-1:0]    imm16;
	instrOp_e            op;
	logic                typeR;
	logic                typeI;

	////////////////////////////////////////
	// Credit buffer
	////////////////////////////////////////

	assign headValid    = (count != '0);
	assign pop          = headValid && !stall; // Head leaves into execute
	assign creditReturn = pop;                  // One credit back per issue
	assign headWord     = buffer[rdPtr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (instrValid)
				wrPtr <= wrPtr + 1'b1; // Sender holds a credit, never full
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({instrValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (instrValid)
			buffer[wrPtr] <= instr;
	end

	////////////////////////////////////////
	// Field extraction and opcode
	////////////////////////////////////////

	assign opc   = opcode_t'(headWord >> OPC_LSB);
	assign funct = opcode_t'(headWord >> FUNCT_LSB);
	assign rs    = regAddr_t'(headWord >> RS_LSB);
	assign rt    = regAddr_t'(headWord >> RT_LSB);
	assign rd    = regAddr_t'(headWord >> RD_LSB);
	assign imm16 = headWord[IMM_LSB +: IMM_W];

	always_comb
	begin
		case (opc)
			OPC_SPECIAL:
			begin
				case (funct)
					FN_ADDU: op = opAddu;
					FN_SUBU: op = opSubu;
					FN_SLL:  op = opSll;
					default: op = opNop; // Unsupported funct
				endcase
			end
			OPC_ORI:   op = opOri;
			OPC_ADDIU: op = opAddiu;
			OPC_LUI:   op = opLui;
			OPC_LW:    op = opLw;
			OPC_SW:    op = opSw;
			default:   op = opNop;
		endcase
		if (headWord == '0)
			op = opNop; // All-zero word is the canonical nop
	end

	assign typeR = (op == opAddu) || (op == opSubu);
	assign typeI = (op == opOri) || (op == opAddiu);

	////////////////////////////////////////
	// Address and Tuse/Tnew table
	////////////////////////////////////////

	always_comb
	begin
		head.op    = op;
		head.shamt = shamt_t'(headWord >> SHAMT_LSB);
		case (op)
			opOri:   head.imm = {16'h0, imm16};              // Zero extend
			opLui:   head.imm = {imm16, 16'h0};              // Upper half
			default: head.imm = {{16{imm16[15]}}, imm16};   // Sign extend
		endcase
		// Nop row is the default
		head.rAddr0 = '0;
		head.rAddr1 = '0;
		head.wAddr  = '0;
		head.tuse0  = NEVER_USED;
		head.tuse1  = NEVER_USED;
		head.tnew   = 3'd0;
		if (typeR)
		begin
			head.rAddr0 = rs;
			head.rAddr1 = rt;
			head.wAddr  = rd;
			head.tuse0  = 3'd1;
			head.tuse1  = 3'd1;
			head.tnew   = 3'd1;
		end
		else if (op == opSll)
		begin
			head.rAddr1 = rt; // Shift source is rt
			head.wAddr  = rd;
			head.tuse1  = 3'd1;
			head.tnew   = 3'd1;
		end
		else if (typeI)
		begin
			head.rAddr0 = rs;
			head.wAddr  = rt;
			head.tuse0  = 3'd1;
			head.tnew   = 3'd1;
		end
		else if (op == opLw)
		begin
			head.rAddr0 = rs;
			head.wAddr  = rt;
			head.tuse0  = 3'd1; // Address in execute
			head.tnew   = 3'd2; // Data only in result
		end
		else if (op == opSw)
		begin
			head.rAddr0 = rs;
			head.rAddr1 = rt;
			head.tuse0  = 3'd1;
			head.tuse1  = 3'd2; // Store data consumed in result
		end
		else if (op == opLui)
		begin
			head.wAddr = rt;
			head.tnew  = 3'd1;
		end
	end

	// Head and its read data go straight into the execute register
	assign issue      = head;
	assign issueValid = pop;
	assign issueData0 = rData0;
	assign issueData1 = rData1;

endmodule

`default_nettype wire

// File: hw/hazardControl.sv
`timescale 1ns/10ps
`default_nettype none

module hazardControl import pipePkg::*;
(
	input  decoded_t head,
	input  logic     headValid,
	input  execOut_t exec,
	input  logic     execValid,
	output logic     stall,
	output fwdSel_e  fwd0,
	output fwdSel_e  fwd1
);

	logic    execWrites;
	timing_t execLeft; // Remaining stages of the execute producer
	logic    hit0;
	logic    hit1;
	logic    stall0;
	logic    stall1;

	// Source choice for one operand
	function automatic fwdSel_e pickSource(logic hit, timing_t tuse, timing_t left);
		fwdSel_e sel;
		if (hit && (left == '0))
			sel = fwdExec;   // ALU value ready at result entry
		else if (tuse != NEVER_USED)
			sel = fwdResult; // Writer may be in result, checked by address
		else
			sel = fwdReg;
		return sel;
	endfunction

	assign execWrites = execValid && (exec.tnew != '0) && (exec.wAddr != '0);
	assign execLeft   = exec.tnew - timing_t'(1);

	assign hit0 = execWrites && (head.tuse0 != NEVER_USED) && (head.rAddr0 == exec.wAddr);
	assign hit1 = execWrites && (head.tuse1 != NEVER_USED) && (head.rAddr1 == exec.wAddr);

	// Value later than the operand needs it
	assign stall0 = hit0 && (execLeft >= head.tuse0);
	assign stall1 = hit1 && (execLeft >= head.tuse1);
	assign stall  = headValid && (stall0 || stall1); // Load-use in practice

	assign fwd0 = pickSource(hit0, head.tuse0, execLeft);
	assign fwd1 = pickSource(hit1, head.tuse1, execLeft);

endmodule

`default_nettype wire

// File: hw/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit import mipsIsaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  decoded_t issue,
	input  logic     issueValid,
	input  word_t    issueData0,
	input  word_t    issueData1,
	input  fwdSel_e  fwd0,
	input  fwdSel_e  fwd1,
	input  regAddr_t wbAddr,
	input  word_t    wbData,
	output execOut_t exec,
	output logic     execValid
);

	decoded_t exReg;
	logic     exValid;
	word_t    exOpnd0;
	word_t    exOpnd1;
	word_t    opnd0;
	word_t    opnd1;
	word_t    aluResult;

	// Operand mux in front of the execute register
	function automatic word_t forwardOperand(fwdSel_e sel, regAddr_t addr, word_t regData,
			word_t aluValue, regAddr_t wrAddr, word_t wrData);
		word_t value;
		value = regData;
		case (sel)
			fwdExec:
				value = aluValue; // Instruction one ahead
			fwdResult:
			begin
				if ((addr != '0) && (addr == wrAddr))
					value = wrData; // Writer in result this cycle
			end
			default:
				value = regData;
		endcase
		return value;
	endfunction

	assign opnd0 = forwardOperand(fwd0, issue.rAddr0, issueData0, aluResult, wbAddr, wbData);
	assign opnd1 = forwardOperand(fwd1, issue.rAddr1, issueData1, aluResult, wbAddr, wbData);

	always_ff @(posedge clk)
	begin
		if (reset)
			exValid <= 1'b0;
		else
			exValid <= issueValid; // Bubble on stall
	end

	always_ff @(posedge clk)
	begin
		exReg   <= issue;
		exOpnd0 <= opnd0;
		exOpnd1 <= opnd1;
	end

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb
	begin
		case (exReg.op)
			opAddu:  aluResult = exOpnd0 + exOpnd1;
			opSubu:  aluResult = exOpnd0 - exOpnd1;
			opSll:   aluResult = exOpnd1 << exReg.shamt;
			opOri:   aluResult = exOpnd0 | exReg.imm;
			opAddiu,
			opLw,
			opSw:    aluResult = exOpnd0 + exReg.imm; // Also address generation
			opLui:   aluResult = exReg.imm;
			default: aluResult = '0;
		endcase
	end

	always_comb
	begin
		exec.op        = exReg.op;
		exec.wAddr     = exReg.wAddr;
		exec.tnew      = exReg.tnew;
		exec.result    = aluResult;
		exec.storeData = exOpnd1;      // May still be stale after lw
		exec.storeAddr = exReg.rAddr1;
	end

	assign execValid = exValid;

endmodule

`default_nettype wire

// File: hw/resultStage.sv
`timescale 1ns/10ps
`default_nettype none

module resultStage import mipsIsaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  execOut_t exec,
	input  logic     execValid,
	input  regAddr_t rAddr0,
	input  regAddr_t rAddr1,
	output word_t    rData0,
	output word_t    rData1,
	output regAddr_t wbAddr,
	output word_t    wbData,
	output logic     retireValid,
	output retire_t  retire
);

	execOut_t           rsReg;
	logic               rsValid;
	word_t              regs [2**$bits(regAddr_t)];
	word_t              dmem [DMEM_WORDS];
	logic               lastWbEn;   // Writeback of the previous cycle
	regAddr_t           lastWbAddr;
	word_t              lastWbData;
	logic [DMEM_AW-1:0] memIdx;
	logic               wbEn;
	logic               memWrite;
	word_t              loadData;
	word_t              storeData;
	word_t              wbValue;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rsValid  <= 1'b0;
			lastWbEn <= 1'b0;
		end
		else
		begin
			rsValid  <= execValid;
			lastWbEn <= wbEn && (rsReg.wAddr != '0); // r0 never forwards
		end
	end

	always_ff @(posedge clk)
	begin
		rsReg      <= exec;
		lastWbAddr <= rsReg.wAddr;
		lastWbData <= wbValue;
	end

	////////////////////////////////////////
	// Memory access and writeback
	////////////////////////////////////////

	assign memIdx   = rsReg.result[DMEM_LSB +: DMEM_AW];
	assign loadData = dmem[memIdx];
	assign memWrite = rsValid && (rsReg.op == opSw);
	assign wbEn     = rsValid && (rsReg.tnew != '0);
	assign wbValue  = (rsReg.op == opLw) ? loadData : rsReg.result;
	assign wbAddr   = wbEn ? rsReg.wAddr : '0; // Zero means no writer
	assign wbData   = wbValue;

	// Late store-data forward, producer wrote one cycle ago
	assign storeData = (lastWbEn && (lastWbAddr == rsReg.storeAddr)) ? lastWbData
		: rsReg.storeData;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (memWrite)
			dmem[memIdx] <= storeData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**$bits(regAddr_t); i++)
				regs[i] <= '0;
		end
		else if (wbEn && (rsReg.wAddr != '0))
			regs[rsReg.wAddr] <= wbValue; // r0 stays zero
	end

	// Write-before-read bypass for the decode head
	assign rData0 = (rAddr0 == '0) ? '0 : (rAddr0 == wbAddr) ? wbData : regs[rAddr0];
	assign rData1 = (rAddr1 == '0) ? '0 : (rAddr1 == wbAddr) ? wbData : regs[rAddr1];

	////////////////////////////////////////
	// Retire report
	////////////////////////////////////////

	assign retireValid = rsValid; // Every instruction, nops included

	always_comb
	begin
		retire.regWrite = wbEn;
		retire.wAddr    = wbEn ? rsReg.wAddr : '0;
		retire.wData    = wbEn ? wbValue : '0;
		retire.memWrite = memWrite;
		retire.memAddr  = memWrite ? rsReg.result : '0;
		retire.memData  = memWrite ? storeData : '0;
	end

endmodule

`default_nettype wire

// File: hw/pipeCore.sv
`timescale 1ns/10ps
`default_nettype none

module pipeCore import mipsIsaPkg::*, pipePkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    instrValid,
	input  word_t   instr,
	output logic    creditReturn,
	output logic    retireValid,
	output retire_t retire
);

	decoded_t head;
	logic     headValid;
	decoded_t issue;
	logic     issueValid;
	word_t    issueData0;
	word_t    issueData1;
	word_t    rData0;
	word_t    rData1;
	logic     stall;
	fwdSel_e  fwd0;
	fwdSel_e  fwd1;
	execOut_t exec;
	logic     execValid;
	regAddr_t wbAddr;
	word_t    wbData;

	// Decode stage with credit buffer
	instrDecoder decoder_i (
		.clk          (clk),
		.reset        (reset),
		.instrValid   (instrValid),
		.instr        (instr),
		.creditReturn (creditReturn),
		.stall        (stall),
		.rData0       (rData0),
		.rData1       (rData1),
		.head         (head),
		.headValid    (headValid),
		.issue        (issue),
		.issueValid   (issueValid),
		.issueData0   (issueData0),
		.issueData1   (issueData1)
	);

	hazardControl hazard_i (
		.head      (head),
		.headValid (headValid),
		.exec      (exec),      // Producer in execute
		.execValid (execValid),
		.stall     (stall),
		.fwd0      (fwd0),
		.fwd1      (fwd1)
	);

	execUnit exec_i (
		.clk        (clk),
		.reset      (reset),
		.issue      (issue),
		.issueValid (issueValid),
		.issueData0 (issueData0),
		.issueData1 (issueData1),
		.fwd0       (fwd0),
		.fwd1       (fwd1),
		.wbAddr     (wbAddr),
		.wbData     (wbData),
		.exec       (exec),
		.execValid  (execValid)
	);

	// Register file reads follow the decode head
	resultStage result_i (
		.clk         (clk),
		.reset       (reset),
		.exec        (exec),
		.execValid   (execValid),
		.rAddr0      (head.rAddr0),
		.rAddr1      (head.rAddr1),
		.rData0      (rData0),
		.rData1      (rData1),
		.wbAddr      (wbAddr),
		.wbData      (wbData),
		.retireValid (retireValid),
		.retire      (retire)
	);

endmodule

`default_nettype wire

// File: testbench/pipeCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module pipeCoreTb import mipsIsaPkg::*, pipePkg::*;
();

	logic    clk = 1'b0;
	logic    reset;
	logic    instrValid;
	word_t   instr;
	logic    creditReturn;
	logic    retireValid;
	retire_t retire;

	int      credits = IN_CREDITS; // Sender side credit counter
	int      sentCount = 0;
	int      returnCount = 0;
	int      retireCount = 0;
	int      checkCount = 0;
	int      errorCount = 0;
	int      cycleCount = 0;
	logic    randomGaps = 1'b0;
	string   testName = "reset";
	retire_t expQ [$];   // Expected retirements in program order
	string   nameQ [$];  // Test that sent each entry
	word_t   modelRegs [32];
	word_t   modelMem [DMEM_WORDS];

	always #50 clk = ~clk; // 100 ns period

	pipeCore dut_i (
		.clk          (clk),
		.reset        (reset),
		.instrValid   (instrValid),
		.instr        (instr),
		.creditReturn (creditReturn),
		.retireValid  (retireValid),
		.retire       (retire)
	);

	////////////////////////////////////////
	// Encoding, model and checking
	////////////////////////////////////////

	function automatic word_t encodeR(opcode_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
			shamt_t sh);
		return {OPC_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t encodeI(opcode_t opc, regAddr_t rs, regAddr_t rt,
			logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	task automatic checkValue(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Architectural execution of one word, in program order
	task automatic runModel(input word_t w, output retire_t exp);
		regAddr_t rs;
		regAddr_t rt;
		word_t    simm;
		word_t    addr;
		logic     doWrite;
		regAddr_t wa;
		word_t    wv;
		rs      = w[25:21];
		rt      = w[20:16];
		simm    = {{16{w[15]}}, w[15:0]};
		addr    = modelRegs[rs] + simm;
		exp     = '0;
		doWrite = 1'b1;
		wa      = rt; // I type target
		wv      = '0;
		if (w == '0)
			doWrite = 1'b0; // Plain nop
		else
		begin
			case (w[31:26])
				OPC_SPECIAL:
				begin
					wa = w[15:11];
					case (w[5:0])
						FN_ADDU: wv = modelRegs[rs] + modelRegs[rt];
						FN_SUBU: wv = modelRegs[rs] - modelRegs[rt];
						FN_SLL:  wv = modelRegs[rt] << w[10:6];
						default: doWrite = 1'b0; // Unknown funct is a nop
					endcase
				end
				OPC_ADDIU: wv = modelRegs[rs] + simm;
				OPC_ORI:   wv = modelRegs[rs] | {16'h0, w[15:0]};
				OPC_LUI:   wv = {w[15:0], 16'h0};
				OPC_LW:    wv = modelMem[addr[7:2]];
				OPC_SW:
				begin
					doWrite      = 1'b0;
					exp.memWrite = 1'b1;
					exp.memAddr  = addr;
					exp.memData  = modelRegs[rt];
					modelMem[addr[7:2]] = modelRegs[rt];
				end
				default:   doWrite = 1'b0;
			endcase
		end
		if (doWrite)
		begin
			exp.regWrite = 1'b1; // Reported even for r0
			exp.wAddr    = wa;
			exp.wData    = wv;
			if (wa != '0)
				modelRegs[wa] = wv;
		end
	endtask

	// Driver, always entered and left 1 ns after a rising edge
	task automatic sendWord(input word_t w);
		int      gap;
		retire_t exp;
		gap = randomGaps ? ($urandom % 4) : 0;
		repeat (gap)
		begin
			@(posedge clk);
			#1;
		end
		while (credits == 0) // Wait for a returned credit
		begin
			@(posedge clk);
			#1;
		end
		instrValid = 1'b1;
		instr      = w;
		credits--;
		sentCount++;
		runModel(w, exp);
		expQ.push_back(exp);
		nameQ.push_back(testName);
		@(posedge clk);
		#1;
		instrValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
		repeat (3) @(posedge clk); // Catch stray retirements
		#1;
	endtask

	task automatic printCounts();
		$display("Checks %0d, errors %0d, sent %0d, retired %0d, credits returned %0d",
			checkCount, errorCount, sentCount, retireCount, returnCount);
	endtask

	////////////////////////////////////////
	// Monitor and watchdog
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (creditReturn === 1'b1)
			begin
				returnCount++;
				credits++;
				if (returnCount > sentCount)
				begin
					errorCount++;
					$display("Credit returned for an instruction that was never sent");
				end
			end
			if (retireValid === 1'b1)
			begin
				retireCount++;
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("Instruction retired while none was outstanding");
				end
				else
					checkValue(nameQ.pop_front(), expQ.pop_front(), retire);
			end
		end
	end

	initial
	begin
		while (cycleCount <= 20 * sentCount + 200) // Grows with traffic
		begin
			@(posedge clk);
			cycleCount++;
		end
		errorCount++;
		$display("Run stopped after %0d cycles with %0d retirements still missing",
			cycleCount, expQ.size());
		printCounts();
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic aluIndependent();
		testName   = "aluIndependent";
		randomGaps = 1'b0;
		sendWord(encodeI(OPC_ADDIU, 0, 1, 16'h1234));
		sendWord('0);
		sendWord(encodeI(OPC_ORI, 0, 2, 16'hf0f0)); // Zero extended
		sendWord('0);
		sendWord(encodeI(OPC_LUI, 0, 3, 16'habcd));
		sendWord('0);
		sendWord(encodeR(FN_SLL, 0, 1, 4, 4));
		sendWord('0);
		sendWord(encodeR(FN_ADDU, 1, 2, 5, 0));
		sendWord('0);
		sendWord(encodeR(FN_SUBU, 1, 2, 6, 0)); // Wraps negative
		sendWord('0);
		sendWord(encodeI(OPC_ADDIU, 0, 8, 16'hfff0)); // Sign extended
		sendWord('0);
		sendWord(encodeI(OPC_ADDIU, 1, 0, 16'h0005)); // Write to r0
		sendWord('0);
		sendWord(encodeR(FN_ADDU, 0, 1, 7, 0)); // r0 must still read zero
		waitDrain();
	endtask

	// Every word reads the result of the one before
	task automatic depChain();
		testName = "depChain";
		sendWord(encodeI(OPC_ADDIU, 0, 9, 16'h0001));
		sendWord(encodeR(FN_ADDU, 9, 9, 9, 0));
		sendWord(encodeR(FN_ADDU, 9, 9, 10, 0));
		sendWord(encodeR(FN_SUBU, 10, 9, 11, 0));
		sendWord(encodeR(FN_SLL, 0, 11, 12, 3));
		sendWord(encodeI(OPC_ORI, 12, 13, 16'h0055));
		sendWord(encodeI(OPC_ADDIU, 13, 14, 16'hfff9));
		sendWord(encodeR(FN_ADDU, 14, 13, 15, 0)); // Distance two on rt
		waitDrain();
	endtask

	task automatic loadUse();
		testName = "loadUse";
		sendWord(encodeI(OPC_ADDIU, 0, 16, 16'h0077));
		sendWord(encodeI(OPC_ADDIU, 0, 17, 16'h0040));
		sendWord(encodeI(OPC_SW, 17, 16, 16'h0000));
		sendWord(encodeI(OPC_LW, 17, 18, 16'h0000));
		sendWord(encodeR(FN_ADDU, 18, 18, 19, 0)); // Needs one stall
		sendWord(encodeI(OPC_LW, 17, 20, 16'h0000));
		sendWord(encodeI(OPC_ADDIU, 20, 21, 16'h0001));
		waitDrain();
	endtask

	task automatic storeForward();
		testName = "storeForward";
		sendWord(encodeI(OPC_ADDIU, 0, 22, 16'h0080));
		sendWord(encodeI(OPC_ADDIU, 0, 23, 16'h3c3c));
		sendWord(encodeR(FN_ADDU, 23, 23, 24, 0));
		sendWord(encodeI(OPC_SW, 22, 24, 16'h0004)); // Data from addu in execute
		sendWord(encodeI(OPC_LW, 22, 25, 16'h0004));
		sendWord(encodeI(OPC_SW, 22, 25, 16'h0008)); // Late forward from lw
		sendWord(encodeI(OPC_LW, 22, 26, 16'h0008));
		waitDrain();
	endtask

	task automatic creditBursts();
		word_t    rnd;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		testName   = "creditBursts";
		randomGaps = 1'b1;
		for (int i = 0; i < 80; i++)
		begin
			rnd = $urandom;
			rs  = {2'b00, rnd[2:0]}; // Small register window, many hazards
			rt  = {2'b00, rnd[5:3]};
			rd  = {2'b00, rnd[8:6]};
			case (rnd[31:29])
				3'd0:    sendWord(encodeR(FN_ADDU, rs, rt, rd, 0));
				3'd1:    sendWord(encodeR(FN_SUBU, rs, rt, rd, 0));
				3'd2:    sendWord(encodeI(OPC_ADDIU, rs, rt, rnd[24:9]));
				3'd3:    sendWord(encodeI(OPC_LW, rs, rt, rnd[24:9]));
				3'd4:    sendWord(encodeI(OPC_SW, rs, rt, rnd[24:9]));
				3'd5:    sendWord(encodeI(OPC_LW, 0, rt, {8'h0, rnd[16:11], 2'b00}));
				3'd6:    sendWord(encodeI(OPC_ORI, rs, rt, rnd[24:9]));
				default: sendWord(encodeR(FN_SLL, 0, rt, rd, rnd[13:9]));
			endcase
		end
		waitDrain();
		checkValue("creditReturnTotal", sentCount, returnCount);
		checkValue("creditsHeld", IN_CREDITS, credits);
	endtask

	initial
	begin
		int unsigned seedInit;
		seedInit   = $urandom(32'h2073fb40);
		reset      = 1'b1;
		instrValid = 1'b0;
		instr      = '0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			modelMem[i] = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		aluIndependent();
		depChain();
		loadUse();
		storeForward();
		creditBursts();
		printCounts();
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
hw/mipsIsaPkg.sv
hw/pipePkg.sv
hw/instrDecoder.sv
hw/hazardControl.sv
hw/execUnit.sv
hw/resultStage.sv
hw/pipeCore.sv
testbench/pipeCoreTb.sv

// File: Bender.yml
package:
  name: pipe_core

sources:
  - files:
      - hw/mipsIsaPkg.sv
      - hw/pipePkg.sv
      - hw/instrDecoder.sv
      - hw/hazardControl.sv
      - hw/execUnit.sv
      - hw/resultStage.sv
      - hw/pipeCore.sv

  - target: test
    files:
      - testbench/pipeCoreTb.sv
